//--- verilog.f
verilog/pce_pad_pkg.sv
verilog/pce_cart_pkg.sv
verilog/pad_encoder.sv
verilog/tap_scanner.sv
verilog/cart_loader.sv
verilog/pce_io_top.sv
tests/tb_clock.sv
tests/pce_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pce_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pce_io_tb -f verilog.f -o pce_io_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/pce_io_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
  exit 0
fi
exit 1

//--- tests/pce_io_tb.sv
`default_nettype none

module pce_io_tb;

  localparam int CART_WORDS = 4250;
  // reset, plain, multitap, six-button, turbo, cart
  localparam int TEST_CYCLES = 8 + 320 + 160 + 108 + 320 + 2 * CART_WORDS + 20;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic clk_sys_42_95;
  logic arst_n;
  pce_pad_pkg::pad_array_t pads;
  pce_pad_pkg::pad_bus_t bus;
  logic turbo_tap_enable;
  logic button6_enable;
  pce_pad_pkg::turbo_speed_e button1_turbo_speed;
  pce_pad_pkg::turbo_speed_e button2_turbo_speed;
  logic ioctl_wr;
  logic [15:0] ioctl_dout;
  logic cart_download;
  logic [3:0] joy_in;
  pce_cart_pkg::rom_addr_t rom_wr_addr;
  logic rom_wr_toggle;
  logic [1:0] populous;

  // reference model state
  pce_pad_pkg::pad_bus_t m_bus_q;
  logic [2:0] m_port;
  logic m_high;
  logic [3:0] m_phase;
  logic [3:0] exp_joy;
  logic [15:0] cur_word;
  logic m_dl_q;
  logic m_wr_q;
  logic [23:0] exp_addr;
  logic exp_toggle;
  logic [1:0] exp_pop;

  logic [31:0] rng_state;
  int err_count;
  int tests_run;
  int tests_failed;
  int cycle_count = 0;

  tb_clock clock_i (
    .clk    (clk_sys_42_95),
    .arst_n (arst_n)
  );

  pce_io_top dut_i (
    .clk_sys_42_95       (clk_sys_42_95),
    .arst_n              (arst_n),
    .pads                (pads),
    .bus                 (bus),
    .turbo_tap_enable    (turbo_tap_enable),
    .button6_enable      (button6_enable),
    .button1_turbo_speed (button1_turbo_speed),
    .button2_turbo_speed (button2_turbo_speed),
    .joy_in              (joy_in),
    .ioctl_wr            (ioctl_wr),
    .ioctl_dout          (ioctl_dout),
    .cart_download       (cart_download),
    .rom_wr_addr         (rom_wr_addr),
    .rom_wr_toggle       (rom_wr_toggle),
    .populous            (populous)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // slow and fast gate on a phase bit, anything else is always on
  function automatic logic turbo_on(pce_pad_pkg::turbo_speed_e s, logic [3:0] phase);
    logic on;
    on = 1'b1;
    if (s == pce_pad_pkg::turbo_slow) on = phase[2];
    if (s == pce_pad_pkg::turbo_fast) on = phase[1];
    return on;
  endfunction

  // expected port word, built nibble by nibble
  function automatic logic [15:0] word_for(pce_pad_pkg::pad_buttons_t p, logic [3:0] phase,
                                           logic six, pce_pad_pkg::turbo_speed_e s1,
                                           pce_pad_pkg::turbo_speed_e s2);
    logic b1;
    logic b2;
    b1 = p.b1;
    b2 = p.b2;
    // III and IV fire I and II on two-button pads
    if (!six) begin
      b1 = p.b1 | (turbo_on(s1, phase) & p.b3);
      b2 = p.b2 | (turbo_on(s2, phase) & p.b4);
    end
    return {4'h0, ~{p.b6, p.b5, p.b4, p.b3}, ~{p.left, p.down, p.right, p.up},
            ~{p.start, p.select, b2, b1}};
  endfunction

  // signature words at offsets 6, 8, 10, 12
  function automatic logic [15:0] sig_word(logic [3:0] off);
    logic [15:0] w;
    case (off)
      4'd6: w = 16'h4F50;
      4'd8: w = 16'h5550;
      4'd10: w = 16'h4F4C;
      default: w = 16'h5355;
    endcase
    return w;
  endfunction

  // header or raw region, at a signature offset
  function automatic logic sig_slot(logic [23:0] a);
    return (a[23:4] == 20'h212 || a[23:4] == 20'h1F2) &&
           (a[3:0] inside {4'd6, 4'd8, 4'd10, 4'd12});
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
    err_count++;
  endtask

  // current port word, absent past port 3
  always_comb begin
    if (m_port < 3'd4) begin
      cur_word = word_for(pads[m_port[1:0]], m_phase, button6_enable,
                          button1_turbo_speed, button2_turbo_speed);
    end else begin
      cur_word = 16'h0FFF;
    end
  end

  always @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      m_bus_q <= '0;
      m_port <= '0;
      m_high <= 1'b0;
      m_phase <= '0;
      exp_joy <= '0;
      m_dl_q <= 1'b0;
      m_wr_q <= 1'b0;
      exp_addr <= '0;
      exp_toggle <= 1'b0;
      exp_pop <= 2'b11;
    end else begin
      m_bus_q <= bus;
      m_dl_q <= cart_download;
      m_wr_q <= ioctl_wr;
      // clr high reads zero and restarts the tap
      if (bus.clr) begin
        exp_joy <= '0;
        m_port <= '0;
        if (!m_bus_q.clr) begin
          m_phase <= m_phase + 4'd1;
          m_high <= button6_enable ? ~m_high : 1'b0;
        end
      end else begin
        // nibble number is {high flag, sel}
        exp_joy <= 4'(cur_word >> {m_high, bus.sel, 2'b00});
        if (bus.sel && !m_bus_q.sel && turbo_tap_enable) begin
          m_port <= m_port + 3'd1;
        end
      end
      // loader
      if (cart_download && !m_dl_q) begin
        exp_addr <= '0;
        exp_pop <= 2'b11;
      end else if (ioctl_wr && !m_wr_q) begin
        exp_toggle <= ~exp_toggle;
        if (sig_slot(exp_addr) && ioctl_dout != sig_word(exp_addr[3:0])) begin
          exp_pop[exp_addr[13]] <= 1'b0;
        end
      end else if (!ioctl_wr && m_wr_q) begin
        exp_addr <= exp_addr + 24'd2;
      end
    end
  end

  a_joy: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n) joy_in == exp_joy)
    else report_mismatch("joy_in", 32'($sampled(joy_in)), 32'($sampled(exp_joy)));

  a_clr_zero: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n)
    bus.clr |=> joy_in == 4'h0)
    else report_mismatch("joy_in after clr", 32'($sampled(joy_in)), 32'd0);

  a_addr: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n)
    rom_wr_addr == exp_addr)
    else report_mismatch("rom_wr_addr", 32'($sampled(rom_wr_addr)), 32'($sampled(exp_addr)));

  a_toggle: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n)
    rom_wr_toggle == exp_toggle)
    else report_mismatch("rom_wr_toggle", 32'($sampled(rom_wr_toggle)),
                         32'($sampled(exp_toggle)));

  a_pop: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n) populous == exp_pop)
    else report_mismatch("populous", 32'($sampled(populous)), 32'($sampled(exp_pop)));

  // run limit
  always @(posedge clk_sys_42_95) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: tests still running after %0d cycles", cycle_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic draw_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic load_random_pads();
    logic [31:0] r;
    for (int i = 0; i < pce_pad_pkg::NUM_PADS; i++) begin
      draw_random(r);
      pads[2'(i)] = pce_pad_pkg::pad_buttons_t'(r[11:0]);
    end
  endtask

  // one cycle of bus lines, set on the falling edge
  task automatic drive_bus(logic clr, logic sel);
    @(negedge clk_sys_42_95);
    bus.clr = clr;
    bus.sel = sel;
  endtask

  // clr pulse, then sel low/high pairs
  task automatic scan_round(int sel_pairs, logic new_pads);
    drive_bus(1'b1, 1'b1);
    if (new_pads) load_random_pads();
    drive_bus(1'b0, 1'b1);
    repeat (sel_pairs) begin
      drive_bus(1'b0, 1'b0);
      drive_bus(1'b0, 1'b1);
    end
  endtask

  task automatic write_word(logic [15:0] data);
    @(negedge clk_sys_42_95);
    ioctl_wr = 1'b1;
    ioctl_dout = data;
    @(negedge clk_sys_42_95);
    ioctl_wr = 1'b0;
  endtask

  task automatic end_test(string name, int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  initial begin
    int errs;
    logic [31:0] r;
    logic [15:0] data;
    logic [23:0] addr;
    pads = '0;
    bus = '0;
    turbo_tap_enable = 1'b0;
    button6_enable = 1'b0;
    button1_turbo_speed = pce_pad_pkg::turbo_off;
    button2_turbo_speed = pce_pad_pkg::turbo_off;
    ioctl_wr = 1'b0;
    ioctl_dout = '0;
    cart_download = 1'b0;
    rng_state = 32'ha8ff;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    @(posedge arst_n);

    errs = err_count;
    assert (joy_in == 4'h0) else report_mismatch("joy_in", 32'(joy_in), 32'd0);
    assert (rom_wr_addr == '0) else report_mismatch("rom_wr_addr", 32'(rom_wr_addr), 32'd0);
    assert (rom_wr_toggle == 1'b0)
      else report_mismatch("rom_wr_toggle", 32'(rom_wr_toggle), 32'd0);
    assert (populous == 2'b11) else report_mismatch("populous", 32'(populous), 32'd3);
    repeat (4) drive_bus(1'b0, 1'b0);
    end_test("reset values", errs);

    // player 1 only, nibbles 0 and 1
    errs = err_count;
    for (int n = 0; n < 40; n++) scan_round(3, 1'b1);
    end_test("plain scan", errs);

    // walk the tap past the last pad
    errs = err_count;
    turbo_tap_enable = 1'b1;
    for (int n = 0; n < 10; n++) scan_round(7, 1'b1);
    turbo_tap_enable = 1'b0;
    end_test("multitap", errs);

    errs = err_count;
    button6_enable = 1'b1;
    for (int n = 0; n < 12; n++) scan_round(2, 1'b1);
    button6_enable = 1'b0;
    for (int n = 0; n < 6; n++) scan_round(2, 1'b1);
    end_test("six-button", errs);

    // III and IV held, every speed pairing
    errs = err_count;
    pads = '0;
    pads[0].b3 = 1'b1;
    pads[0].b4 = 1'b1;
    for (int k = 0; k < 4; k++) begin
      button1_turbo_speed = pce_pad_pkg::turbo_speed_e'(2'(k));
      button2_turbo_speed = pce_pad_pkg::turbo_speed_e'(2'(3 - k));
      for (int n = 0; n < 20; n++) scan_round(1, 1'b0);
    end
    end_test("turbo", errs);

    errs = err_count;
    @(negedge clk_sys_42_95);
    cart_download = 1'b1;
    for (int w = 0; w < CART_WORDS; w++) begin
      addr = 24'(2 * w);
      draw_random(r);
      data = sig_slot(addr) ? sig_word(addr[3:0]) : r[15:0];
      // one bad word in the header image
      if (addr == 24'h002128) data = data ^ 16'h0100;
      write_word(data);
    end
    @(negedge clk_sys_42_95);
    assert (rom_wr_addr == 24'(2 * CART_WORDS))
      else report_mismatch("rom_wr_addr", 32'(rom_wr_addr), 32'(2 * CART_WORDS));
    assert (rom_wr_toggle == 1'(CART_WORDS % 2))
      else report_mismatch("rom_wr_toggle", 32'(rom_wr_toggle), 32'(CART_WORDS % 2));
    assert (populous == 2'b01) else report_mismatch("populous", 32'(populous), 32'd1);
    // second image restarts address and flags
    cart_download = 1'b0;
    @(negedge clk_sys_42_95);
    cart_download = 1'b1;
    repeat (3) write_word(16'h0000);
    @(negedge clk_sys_42_95);
    assert (rom_wr_addr == 24'd6) else report_mismatch("rom_wr_addr", 32'(rom_wr_addr), 32'd6);
    assert (rom_wr_toggle == 1'((CART_WORDS + 3) % 2))
      else report_mismatch("rom_wr_toggle", 32'(rom_wr_toggle), 32'((CART_WORDS + 3) % 2));
    assert (populous == 2'b11) else report_mismatch("populous", 32'(populous), 32'd3);
    cart_download = 1'b0;
    end_test("cart download", errs);

    repeat (2) drive_bus(1'b0, 1'b0);
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic arst_n
);

  localparam int HALF_PERIOD = 4;
  localparam int RESET_CYCLES = 4;

  // free running, period 8
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/pce_io_top.sv
`default_nettype none

module pce_io_top (
  input  wire logic                        clk_sys_42_95,
  input  wire logic                        arst_n,
  // controller side
  input  wire pce_pad_pkg::pad_array_t     pads,
  input  wire pce_pad_pkg::pad_bus_t       bus,
  input  wire logic                        turbo_tap_enable,
  input  wire logic                        button6_enable,
  input  wire pce_pad_pkg::turbo_speed_e   button1_turbo_speed,
  input  wire pce_pad_pkg::turbo_speed_e   button2_turbo_speed,
  output logic [3:0]                       joy_in,
  // cartridge download
  input  wire logic                        ioctl_wr,
  input  wire logic [15:0]                 ioctl_dout,
  input  wire logic                        cart_download,
  output pce_cart_pkg::rom_addr_t          rom_wr_addr,
  output logic                             rom_wr_toggle,
  output logic [1:0]                       populous
);

  // scan count feeds back into turbo
  logic [3:0] turbo_phase;
  pce_pad_pkg::pad_word_array_t words;

  pad_encoder pad_encoder_i (
    .pads                (pads),
    .turbo_phase         (turbo_phase),
    .button6_enable      (button6_enable),
    .button1_turbo_speed (button1_turbo_speed),
    .button2_turbo_speed (button2_turbo_speed),
    .words               (words)
  );

  tap_scanner tap_scanner_i (
    .clk_sys_42_95    (clk_sys_42_95),
    .arst_n           (arst_n),
    .bus              (bus),
    .words            (words),
    .turbo_tap_enable (turbo_tap_enable),
    .button6_enable   (button6_enable),
    .turbo_phase      (turbo_phase),
    .joy_in           (joy_in)
  );

  // independent of the pad path
  cart_loader cart_loader_i (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .cart_download (cart_download),
    .rom_wr_addr   (rom_wr_addr),
    .rom_wr_toggle (rom_wr_toggle),
    .populous      (populous)
  );

endmodule

`default_nettype wire

//--- verilog/cart_loader.sv
`default_nettype none

module cart_loader (
  input  wire logic              clk_sys_42_95,
  input  wire logic              arst_n,
  input  wire logic              ioctl_wr,
  input  wire logic [15:0]       ioctl_dout,
  input  wire logic              cart_download,
  output pce_cart_pkg::rom_addr_t rom_wr_addr,
  output logic                   rom_wr_toggle,
  output logic [1:0]             populous
);

  // previous samples for edge detect
  logic download_q;
  logic wr_q;

  logic download_rise;
  logic wr_rise;
  logic wr_fall;

  // signature check on the current word
  logic in_region;
  logic at_sig;
  logic sig_bad;
  logic flag_sel;
  logic [pce_cart_pkg::REGION_LSB-1:0] offset;
  logic [pce_cart_pkg::REGION_LSB-1:0] sig_rel;
  logic [1:0] sig_idx;

  assign download_rise = cart_download & ~download_q;
  assign wr_rise       = ioctl_wr & ~wr_q;
  assign wr_fall       = ~ioctl_wr & wr_q;

  // either image layout
  assign in_region =
    (rom_wr_addr[pce_cart_pkg::ADDR_W-1:pce_cart_pkg::REGION_LSB] ==
     pce_cart_pkg::POP_REGION_HDR) ||
    (rom_wr_addr[pce_cart_pkg::ADDR_W-1:pce_cart_pkg::REGION_LSB] ==
     pce_cart_pkg::POP_REGION_RAW);

  assign offset  = rom_wr_addr[pce_cart_pkg::REGION_LSB-1:0];
  // word number inside the signature
  assign sig_rel = offset - pce_cart_pkg::POP_SIG_FIRST;
  assign sig_idx = sig_rel[2:1];

  assign at_sig = in_region && !offset[0] &&
                  (offset >= pce_cart_pkg::POP_SIG_FIRST) &&
                  (offset <= pce_cart_pkg::POP_SIG_LAST);

  assign sig_bad  = at_sig && (ioctl_dout != pce_cart_pkg::POP_SIG[sig_idx]);
  // bit 13 separates header and raw images
  assign flag_sel = rom_wr_addr[pce_cart_pkg::POP_FLAG_BIT];

  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      download_q    <= 1'b0;
      wr_q          <= 1'b0;
      rom_wr_addr   <= '0;
      rom_wr_toggle <= 1'b0;
      populous      <= 2'b11;
    end else begin
      download_q <= cart_download;
      wr_q       <= ioctl_wr;
      if (download_rise) begin
        // new image, assume Populous until a word disagrees
        rom_wr_addr <= '0;
        populous    <= 2'b11;
      end else if (wr_rise) begin
        // memory side writes on every toggle
        rom_wr_toggle <= ~rom_wr_toggle;
        if (sig_bad) begin
          populous[flag_sel] <= 1'b0;
        end
      end else if (wr_fall) begin
        rom_wr_addr <= rom_wr_addr + pce_cart_pkg::ADDR_STEP;
      end
    end
  end

  // word writes only, the byte address never goes odd
  a_addr_even: assert property (
    @(posedge clk_sys_42_95) disable iff (!arst_n)
    !rom_wr_addr[0]
  );

endmodule

`default_nettype wire

//--- verilog/tap_scanner.sv
`default_nettype none

module tap_scanner (
  input  wire logic                          clk_sys_42_95,
  input  wire logic                          arst_n,
  input  wire pce_pad_pkg::pad_bus_t         bus,
  input  wire pce_pad_pkg::pad_word_array_t  words,
  input  wire logic                          turbo_tap_enable,
  input  wire logic                          button6_enable,
  output logic [3:0]                         turbo_phase,
  output logic [3:0]                         joy_in
);

  // bus as seen on the previous edge
  pce_pad_pkg::pad_bus_t bus_q;

  // multitap port being read
  logic [pce_pad_pkg::PORT_W-1:0] port;

  // second scan of a six-button pad
  logic high_flag;

  logic clr_rise;
  logic sel_rise;
  logic [1:0] nib_sel;
  pce_pad_pkg::pad_word_t port_word;

  assign clr_rise = bus.clr & ~bus_q.clr;
  assign sel_rise = bus.sel & ~bus_q.sel;

  // nibble order: low pair for the normal scan, high pair for six-button
  assign nib_sel = {high_flag, bus.sel};

  // ports past the tap read as absent
  always_comb begin
    if (int'(port) < pce_pad_pkg::NUM_PORTS) begin
      port_word = words[port];
    end else begin
      port_word = pce_pad_pkg::IDLE_WORD;
    end
  end

  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      bus_q       <= '0;
      port        <= '0;
      high_flag   <= 1'b0;
      turbo_phase <= '0;
      joy_in      <= '0;
    end else begin
      bus_q <= bus;
      if (bus.clr) begin
        // clr held: restart at port 0 and read zeros
        joy_in <= '0;
        port   <= '0;
        if (clr_rise) begin
          // one turbo step per scan
          turbo_phase <= turbo_phase + 4'd1;
          // alternate scans only with six-button pads
          high_flag <= ~high_flag & button6_enable;
        end
      end else begin
        joy_in <= port_word[nib_sel];
        // sel rise moves to the next tap port
        if (sel_rise && turbo_tap_enable) begin
          port <= port + 1'b1;
        end
      end
    end
  end

  // console sees zeros the cycle after clr is seen
  a_clr_zero: assert property (
    @(posedge clk_sys_42_95) disable iff (!arst_n)
    bus.clr |=> (joy_in == 4'h0)
  );

  // with two-button pads the high scan never starts
  a_high_off: assert property (
    @(posedge clk_sys_42_95) disable iff (!arst_n)
    (!button6_enable && (clr_rise || !high_flag)) |=> !high_flag
  );

endmodule

`default_nettype wire

//--- verilog/pad_encoder.sv
`default_nettype none

module pad_encoder (
  input  wire pce_pad_pkg::pad_array_t      pads,
  input  wire logic [3:0]                   turbo_phase,
  input  wire logic                         button6_enable,
  input  wire pce_pad_pkg::turbo_speed_e    button1_turbo_speed,
  input  wire pce_pad_pkg::turbo_speed_e    button2_turbo_speed,
  output pce_pad_pkg::pad_word_array_t      words
);

  // turbo gate for one button setting
  function automatic logic turbo_gate(pce_pad_pkg::turbo_speed_e speed, logic [3:0] phase);
    logic gate;
    case (speed)
      pce_pad_pkg::turbo_slow: gate = phase[pce_pad_pkg::TURBO_SLOW_BIT];
      pce_pad_pkg::turbo_fast: gate = phase[pce_pad_pkg::TURBO_FAST_BIT];
      // off settings leave turbo always on
      pce_pad_pkg::turbo_off,
      pce_pad_pkg::turbo_off_alt: gate = 1'b1;
    endcase
    return gate;
  endfunction

  logic turbo1_en;
  logic turbo2_en;
  pce_pad_pkg::pad_array_t eff;

  assign turbo1_en = turbo_gate(button1_turbo_speed, turbo_phase);
  assign turbo2_en = turbo_gate(button2_turbo_speed, turbo_phase);

  // on two-button pads, III and IV fire I and II with turbo
  always_comb begin
    eff = pads;
    for (int i = 0; i < pce_pad_pkg::NUM_PADS; i++) begin
      if (!button6_enable) begin
        eff[i].b1 = pads[i].b1 | (turbo1_en & pads[i].b3);
        eff[i].b2 = pads[i].b2 | (turbo2_en & pads[i].b4);
      end
    end
  end

  // pack into active-low nibbles
  always_comb begin
    for (int i = 0; i < pce_pad_pkg::NUM_PADS; i++) begin
      words[i][0] = ~{eff[i].start, eff[i].select, eff[i].b2, eff[i].b1};
      words[i][1] = ~{eff[i].left, eff[i].down, eff[i].right, eff[i].up};
      words[i][2] = ~{eff[i].b6, eff[i].b5, eff[i].b4, eff[i].b3};
      words[i][3] = pce_pad_pkg::SIX_BTN_ID;
    end
    // empty fifth tap port
    words[pce_pad_pkg::NUM_PORTS-1] = pce_pad_pkg::IDLE_WORD;
  end

endmodule

`default_nettype wire

//--- verilog/pce_cart_pkg.sv
`default_nettype none

package pce_cart_pkg;

  // byte address into ROM space
  localparam int ADDR_W = 24;
  typedef logic [ADDR_W-1:0] rom_addr_t;

  // one 16-bit download word per write
  localparam rom_addr_t ADDR_STEP = 24'd2;

  // region compare uses address bits above this
  localparam int REGION_LSB = 4;

  // Populous title region, with and without the 512-byte header
  localparam logic [ADDR_W-REGION_LSB-1:0] POP_REGION_HDR = 20'h212;
  localparam logic [ADDR_W-REGION_LSB-1:0] POP_REGION_RAW = 20'h1F2;

  // picks which layout flag a word belongs to
  localparam int POP_FLAG_BIT = 13;

  // signature words sit at offsets 6..12 of the region
  localparam logic [REGION_LSB-1:0] POP_SIG_FIRST = 4'd6;
  localparam logic [REGION_LSB-1:0] POP_SIG_LAST  = 4'd12;
  localparam int POP_SIG_WORDS = 4;

  // "OPUPOLSU" in download word order, word 0 first
  localparam logic [POP_SIG_WORDS-1:0][15:0] POP_SIG = {
    16'h5355,
    16'h4F4C,
    16'h5550,
    16'h4F50
  };

endpackage

`default_nettype wire

//--- verilog/pce_pad_pkg.sv
`default_nettype none

package pce_pad_pkg;

  // player and port counts
  localparam int NUM_PADS = 4;
  // four pads plus one empty port at the end
  localparam int NUM_PORTS = 5;
  // multitap port counter width
  localparam int PORT_W = 3;

  // a port word is four nibbles
  localparam int NIBBLE_W = 4;
  localparam int NUM_NIBBLES = 4;
  // top nibble reads all zero on a six-button pad
  localparam logic [NIBBLE_W-1:0] SIX_BTN_ID = 4'h0;

  // turbo_phase bit that gates each speed
  localparam int TURBO_SLOW_BIT = 2;
  localparam int TURBO_FAST_BIT = 1;

  // one player, pressed = 1
  typedef struct packed {
    logic b6;
    logic b5;
    logic b4;
    logic b3;
    logic start;
    logic select;
    logic b2;
    logic b1;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_buttons_t;

  typedef pad_buttons_t [NUM_PADS-1:0] pad_array_t;

  // speed 3 behaves like speed 0
  typedef enum logic [1:0] {
    turbo_off     = 2'd0,
    turbo_slow    = 2'd1,
    turbo_fast    = 2'd2,
    turbo_off_alt = 2'd3
  } turbo_speed_e;

  // active low, nibble 0 in the low bits
  typedef logic [NUM_NIBBLES-1:0][NIBBLE_W-1:0] pad_word_t;
  typedef pad_word_t [NUM_PORTS-1:0] pad_word_array_t;

  // nothing plugged in
  localparam pad_word_t IDLE_WORD = 16'h0FFF;

  // console output lines, sel in bit 0
  typedef struct packed {
    logic clr;
    logic sel;
  } pad_bus_t;

endpackage

`default_nettype wire
